/* aguCluster.f */
common/aguPkg.sv
hw/agu/addrGen.sv
hw/agu/boundCheck.sv
hw/accessTimer.sv
hw/aguCtrl.sv
hw/aguCluster.sv
tb/aguClusterTb.sv

/* Bender.yml */
package:
  name: agu_cluster

sources:
  - common/aguPkg.sv
  - hw/agu/addrGen.sv
  - hw/agu/boundCheck.sv
  - hw/accessTimer.sv
  - hw/aguCtrl.sv
  - hw/aguCluster.sv
  - target: test
    files:
      - tb/aguClusterTb.sv

/* tb/aguClusterTb.sv */
`timescale 1ns/1ps
`default_nettype none

module aguClusterTb;

	localparam int ackLimit = 100;

	logic clock;
	logic rstN;
	logic opReq;
	logic [63:0] opBase;
	logic [63:0] opIndex;
	logic [15:0] opDisp;
	aguPkg::aguCmd_t opCmd;
	logic [3:0] opIxt;
	logic [33:0] opBound;
	logic wideAddr;
	logic opAck;
	logic [47:0] resAddr;
	logic resOob;
	logic resTimeout;
	logic memReq;
	logic [47:0] memAddr;
	logic memWrite;
	logic memAck = 1'b0;

	logic respEnable;
	logic ackPending = 1'b0;
	int ackDelay = 0;
	int newDelay;
	logic [31:0] lfsrState = 32'h289795b9;
	int errorCount;
	int checkCount;

	aguCluster dut (
		.clock(clock),
		.rstN(rstN),
		.opReq(opReq),
		.opBase(opBase),
		.opIndex(opIndex),
		.opDisp(opDisp),
		.opCmd(opCmd),
		.opIxt(opIxt),
		.opBound(opBound),
		.wideAddr(wideAddr),
		.opAck(opAck),
		.resAddr(resAddr),
		.resOob(resOob),
		.resTimeout(resTimeout),
		.memReq(memReq),
		.memAddr(memAddr),
		.memWrite(memWrite),
		.memAck(memAck)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// fibonacci taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		lfsrNext = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// ack latency 0 to 7 cycles
	task automatic drawDelay(output int d);
		logic [2:0] bits;
		bits = '0;
		for (int i = 0; i < 3; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[1:0], lfsrState[0]};
		end
		d = bits;
	endtask

	// memory side of the four-phase handshake
	always @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			memAck <= 1'b0;
			ackPending <= 1'b0;
			ackDelay <= 0;
		end
		else if (memAck)
		begin
			if (!memReq)
				memAck <= 1'b0;
		end
		else if (ackPending)
		begin
			if (ackDelay == 0)
			begin
				memAck <= 1'b1;
				ackPending <= 1'b0;
			end
			else
				ackDelay <= ackDelay - 1;
		end
		else if (memReq && respEnable)
		begin
			drawDelay(newDelay);
			ackDelay <= newDelay;
			ackPending <= 1'b1;
		end
	end

	// index extended from bit 31 and scaled
	function automatic logic [47:0] extendAndScale(input logic [63:0] index,
		input logic [3:0] ixt);
		logic [47:0] ext;
		ext = ixt[2] ? {16'h0, index[31:0]} : {{16{index[31]}}, index[31:0]};
		extendAndScale = ext << ixt[1:0];
	endfunction

	function automatic logic [47:0] addressModel(input logic [63:0] base,
		input logic [63:0] index, input logic [15:0] disp, input logic [3:0] ixt,
		input logic wide);
		logic [47:0] sum;
		sum = base[47:0] + extendAndScale(index, ixt);
		if (ixt[3])
			sum = sum + {{32{disp[15]}}, disp};
		if (!wide)
			sum[47:32] = 16'h0;
		addressModel = sum;
	endfunction

	function automatic logic oobModel(input logic [63:0] index, input logic [3:0] ixt,
		input logic [33:0] bound, input logic [1:0] cmd);
		logic [47:0] idx;
		idx = extendAndScale(index, ixt);
		if (bound[33:32] != 2'b11)
			oobModel = 1'b0;
		else
			oobModel = idx[47] || (idx[47:32] != 16'h0) || (idx[31:4] >= bound[27:0]) ||
				(bound[28] && cmd == 2'd1) || bound[29];
	endfunction

	task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic reportProblem(input string msg);
		errorCount++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	// drive one request and check its result, opReq stays high for hold cycles after opAck
	task automatic issueOp(input logic [1:0] cmd, input logic [63:0] base,
		input logic [63:0] index, input logic [15:0] disp, input logic [3:0] ixt,
		input logic [33:0] bound, input logic wide, input logic expTimeout, input int hold);
		logic [47:0] expAddr;
		logic expOob;
		logic expAccess;
		logic sawMemReq;
		int waitCount;
		expAddr = addressModel(base, index, disp, ixt, wide);
		expOob = oobModel(index, ixt, bound, cmd);
		expAccess = (cmd == 2'd0 || cmd == 2'd1) && !expOob;
		sawMemReq = 1'b0;
		waitCount = 0;
		@(posedge clock);
		opBase <= base;
		opIndex <= index;
		opDisp <= disp;
		opIxt <= ixt;
		opBound <= bound;
		wideAddr <= wide;
		opCmd <= aguPkg::aguCmd_t'(cmd);
		opReq <= 1'b1;
		@(negedge clock);
		// a new request is never answered on its first cycle
		compare("opAck before processing", opAck, 1'b0);
		while (!opAck && waitCount < ackLimit)
		begin
			if (memReq && !sawMemReq)
			begin
				sawMemReq = 1'b1;
				compare("memAddr", memAddr, expAddr);
				compare("memWrite", memWrite, cmd == 2'd1);
			end
			@(negedge clock);
			waitCount++;
		end
		if (!opAck)
			reportProblem("opAck never rose for the issued operation");
		else
		begin
			compare("memReq issued", sawMemReq, expAccess);
			compare("resAddr", resAddr, expAddr);
			compare("resOob", resOob, expOob);
			compare("resTimeout", resTimeout, expTimeout && expAccess);
			compare("memReq after opAck", memReq, 1'b0);
		end
		repeat (hold)
		begin
			@(negedge clock);
			if (!opAck)
				reportProblem("opAck fell while opReq was still high");
		end
	endtask

	// drop opReq and wait for opAck to fall
	task automatic releaseOp();
		int waitCount;
		waitCount = 0;
		@(posedge clock);
		opReq <= 1'b0;
		@(negedge clock);
		while (opAck && waitCount < ackLimit)
		begin
			@(negedge clock);
			waitCount++;
		end
		if (opAck)
			reportProblem("opAck stayed high after opReq fell");
	endtask

	// one full issue handshake
	task automatic runOp(input logic [1:0] cmd, input logic [63:0] base,
		input logic [63:0] index, input logic [15:0] disp, input logic [3:0] ixt,
		input logic [33:0] bound, input logic wide, input logic expTimeout, input int hold);
		issueOp(cmd, base, index, disp, ixt, bound, wide, expTimeout, hold);
		releaseOp();
	endtask

	task automatic scalingCases();
		for (int s = 0; s < 4; s++)
			for (int z = 0; z < 2; z++)
				for (int d = 0; d < 2; d++)
					runOp(2'd2, 64'h0000_1234_5678_9abc, 64'hffff_ffff_8000_0010, 16'hff80,
						{d[0], z[0], s[1:0]}, 34'h0, 1'b1, 1'b0, 0);
		// reserved command acts as lea
		runOp(2'd3, 64'h0000_0000_0010_0000, 64'h40, 16'h0004, 4'b1011, 34'h0, 1'b1, 1'b0, 0);
	endtask

	task automatic carryCases();
		runOp(2'd2, 64'h0000_0000_0000_ffff, 64'h1, 16'h0, 4'b0100, 34'h0, 1'b0, 1'b0, 0);
		runOp(2'd2, 64'h0000_0000_ffff_ffff, 64'h1, 16'h0, 4'b0100, 34'h0, 1'b1, 1'b0, 0);
		runOp(2'd2, 64'h0000_0000_ffff_ffff, 64'h1, 16'h0, 4'b0100, 34'h0, 1'b0, 1'b0, 0);
		runOp(2'd2, 64'h0000_7fff_ffff_ffff, 64'h1, 16'h0, 4'b0100, 34'h0, 1'b1, 1'b0, 0);
		// borrow through both slice boundaries
		runOp(2'd2, 64'h0000_0001_0000_0000, 64'h0, 16'hffff, 4'b1100, 34'h0, 1'b1, 1'b0, 0);
		runOp(2'd2, 64'hdead_0000_fff0_fff8, 64'h0fff_ffff, 16'h0010, 4'b1111, 34'h0,
			1'b0, 1'b0, 0);
	endtask

	task automatic loadStoreCases();
		runOp(2'd0, 64'h0000_0040_0000_0000, 64'h120, 16'h0010, 4'b1110, 34'h3_0000_1000,
			1'b1, 1'b0, 0);
		runOp(2'd1, 64'h0000_0040_0000_0000, 64'h120, 16'h0010, 4'b1110, 34'h3_0000_1000,
			1'b1, 1'b0, 0);
		runOp(2'd1, 64'h0000_0000_0123_4560, 64'h8, 16'hfff0, 4'b1011, 34'h3_0000_1000,
			1'b0, 1'b0, 0);
	endtask

	task automatic boundsCases();
		runOp(2'd0, 64'h1000_0000, 64'h1000, 16'h0, 4'b0100, 34'h3_0000_0100, 1'b1, 1'b0, 0);
		runOp(2'd0, 64'h1000_0000, 64'hff0, 16'h0, 4'b0100, 34'h3_0000_0100, 1'b1, 1'b0, 0);
		runOp(2'd0, 64'h1000_0000, 64'hffff_ffff_ffff_fff0, 16'h0, 4'b0000, 34'h3_0000_0100,
			1'b1, 1'b0, 0);
		runOp(2'd1, 64'h1000_0000, 64'h10, 16'h0, 4'b0100, 34'h3_1000_0100, 1'b1, 1'b0, 0);
		runOp(2'd0, 64'h1000_0000, 64'h10, 16'h0, 4'b0100, 34'h3_1000_0100, 1'b1, 1'b0, 0);
		runOp(2'd0, 64'h1000_0000, 64'h10, 16'h0, 4'b0100, 34'h3_2000_0100, 1'b1, 1'b0, 0);
		// partial or clear enable skips the check
		runOp(2'd0, 64'h1000_0000, 64'h1000, 16'h0, 4'b0100, 34'h1_0000_0100, 1'b1, 1'b0, 0);
		runOp(2'd1, 64'h1000_0000, 64'h10, 16'h0, 4'b0100, 34'h0_3000_0100, 1'b1, 1'b0, 0);
	endtask

	task automatic timeoutCases();
		@(posedge clock);
		respEnable <= 1'b0;
		runOp(2'd0, 64'h2000_0000, 64'h40, 16'h0, 4'b0100, 34'h0, 1'b1, 1'b1, 0);
		@(posedge clock);
		respEnable <= 1'b1;
		runOp(2'd0, 64'h2000_0000, 64'h40, 16'h0, 4'b0100, 34'h0, 1'b1, 1'b0, 0);
	endtask

	task automatic handshakeCases();
		runOp(2'd0, 64'h3000_0000, 64'h8, 16'h0, 4'b0101, 34'h0, 1'b1, 1'b0, 4);
		runOp(2'd2, 64'h3000_0000, 64'h8, 16'h0, 4'b0101, 34'h0, 1'b1, 1'b0, 2);
		runOp(2'd1, 64'h3000_0000, 64'h8, 16'h0, 4'b0101, 34'h0, 1'b1, 1'b0, 0);
		// next request raised before opAck of the previous one has fallen
		issueOp(2'd2, 64'h3000_0000, 64'h8, 16'h0, 4'b0101, 34'h0, 1'b1, 1'b0, 0);
		@(posedge clock);
		opReq <= 1'b0;
		runOp(2'd0, 64'h3100_0000, 64'h20, 16'h0, 4'b0101, 34'h0, 1'b1, 1'b0, 0);
	endtask

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		rstN = 1'b0;
		opReq = 1'b0;
		opBase = '0;
		opIndex = '0;
		opDisp = '0;
		opCmd = aguPkg::cmdLea;
		opIxt = '0;
		opBound = '0;
		wideAddr = 1'b0;
		respEnable = 1'b1;
		repeat (3) @(posedge clock);
		rstN <= 1'b1;
		@(negedge clock);
		compare("opAck after reset", opAck, 1'b0);
		compare("memReq after reset", memReq, 1'b0);
		scalingCases();
		carryCases();
		loadStoreCases();
		boundsCases();
		timeoutCases();
		handshakeCases();
		$display("checks run %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/aguCluster.sv */
`timescale 1ns/1ps
`default_nettype none

module aguCluster #(
	parameter int unsigned timeoutCycles = 16
) (
	input logic clock,
	input logic rstN,
	input logic opReq,
	input logic [aguPkg::regWidth-1:0] opBase,
	input logic [aguPkg::regWidth-1:0] opIndex,
	input logic [aguPkg::dispWidth-1:0] opDisp,
	input aguPkg::aguCmd_t opCmd,
	input logic [aguPkg::ixtWidth-1:0] opIxt,
	input logic [aguPkg::boundWidth-1:0] opBound,
	input logic wideAddr,
	output logic opAck,
	output logic [aguPkg::addrWidth-1:0] resAddr,
	output logic resOob,
	output logic resTimeout,
	output logic memReq,
	output logic [aguPkg::addrWidth-1:0] memAddr,
	output logic memWrite,
	input logic memAck
);

	logic opLoad;
	logic [aguPkg::addrWidth-1:0] genAddr;
	logic [aguPkg::addrWidth-1:0] scaledIndex;
	aguPkg::aguCmd_t cmdReg;
	logic outOfBounds;
	logic timerRun;
	logic expired;

	aguCtrl uCtrl (
		.clock(clock),
		.rstN(rstN),
		.opReq(opReq),
		.cmd(cmdReg),
		.genAddr(genAddr),
		.outOfBounds(outOfBounds),
		.memAck(memAck),
		.expired(expired),
		.opAck(opAck),
		.opLoad(opLoad),
		.memReq(memReq),
		.memAddr(memAddr),
		.memWrite(memWrite),
		.timerRun(timerRun),
		.resAddr(resAddr),
		.resOob(resOob),
		.resTimeout(resTimeout)
	);

	accessTimer #(
		.timeoutCycles(timeoutCycles)
	) uTimer (
		.clock(clock),
		.rstN(rstN),
		.timerRun(timerRun),
		.expired(expired)
	);

	addrGen uAddrGen (
		.clock(clock),
		.rstN(rstN),
		.opLoad(opLoad),
		.base(opBase),
		.index(opIndex),
		.disp(opDisp),
		.cmd(opCmd),
		.ixt(opIxt),
		.wideAddr(wideAddr),
		.genAddr(genAddr),
		.scaledIndex(scaledIndex),
		.cmdReg(cmdReg)
	);

	// bound word is held by the issuer for the whole handshake
	boundCheck uBoundCheck (
		.scaledIndex(scaledIndex),
		.bound(opBound),
		.cmd(cmdReg),
		.outOfBounds(outOfBounds)
	);

endmodule

`default_nettype wire

/* hw/aguCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module aguCtrl (
	input logic clock,
	input logic rstN,
	input logic opReq,
	input aguPkg::aguCmd_t cmd,
	input logic [aguPkg::addrWidth-1:0] genAddr,
	input logic outOfBounds,
	input logic memAck,
	input logic expired,
	output logic opAck,
	output logic opLoad,
	output logic memReq,
	output logic [aguPkg::addrWidth-1:0] memAddr,
	output logic memWrite,
	output logic timerRun,
	output logic [aguPkg::addrWidth-1:0] resAddr,
	output logic resOob,
	output logic resTimeout
);

	typedef enum logic [2:0]
	{
		IDLE,
		CAPTURE,
		DECIDE,
		MEMREQ,
		MEMREL,
		DONE
	} ctrlState_t;

	ctrlState_t state;
	logic isAccess;

	// reserved command falls through as lea
	assign isAccess = (cmd == aguPkg::cmdLoad) || (cmd == aguPkg::cmdStore);

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			opAck <= 1'b0;
			opLoad <= 1'b0;
			memReq <= 1'b0;
			memWrite <= 1'b0;
			timerRun <= 1'b0;
			resOob <= 1'b0;
			resTimeout <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (opReq)
					begin
						opLoad <= 1'b1;
						resTimeout <= 1'b0;
						state <= CAPTURE;
					end
				end
				CAPTURE:
				begin
					// operands land in addrGen on this edge
					opLoad <= 1'b0;
					state <= DECIDE;
				end
				DECIDE:
				begin
					resOob <= outOfBounds;
					state <= (isAccess && !outOfBounds) ? MEMREQ : DONE;
				end
				MEMREQ:
				begin
					if (!memReq)
					begin
						memReq <= 1'b1;
						memWrite <= (cmd == aguPkg::cmdStore);
						timerRun <= 1'b1;
					end
					else if (memAck)
					begin
						memReq <= 1'b0;
						timerRun <= 1'b0;
						state <= MEMREL;
					end
					else if (expired)
					begin
						// give up on memory, no wait for a late ack
						memReq <= 1'b0;
						timerRun <= 1'b0;
						resTimeout <= 1'b1;
						state <= DONE;
					end
				end
				MEMREL:
				begin
					// timer was idle one cycle, restarts for the release wait
					if (!memAck)
					begin
						timerRun <= 1'b0;
						state <= DONE;
					end
					else if (expired)
					begin
						timerRun <= 1'b0;
						resTimeout <= 1'b1;
						state <= DONE;
					end
					else
						timerRun <= 1'b1;
				end
				DONE:
				begin
					if (!opAck)
						opAck <= 1'b1;
					else if (!opReq)
					begin
						opAck <= 1'b0;
						state <= IDLE;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// result and request address
	always_ff @(posedge clock)
	begin
		if (state == DECIDE)
			resAddr <= genAddr;
		if (state == MEMREQ && !memReq)
			memAddr <= genAddr;
	end

endmodule

`default_nettype wire

/* hw/accessTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module accessTimer #(
	parameter int unsigned timeoutCycles = 16
) (
	input logic clock,
	input logic rstN,
	input logic timerRun,
	output logic expired
);

	localparam int cntWidth = $clog2(timeoutCycles + 1);

	logic [cntWidth-1:0] count;

	// saturates at the limit while running
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			count <= '0;
		else if (!timerRun)
			count <= '0;
		else if (count != cntWidth'(timeoutCycles))
			count <= count + 1'b1;
	end

	assign expired = timerRun && (count == cntWidth'(timeoutCycles));

endmodule

`default_nettype wire

/* hw/agu/boundCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module boundCheck (
	input logic [aguPkg::addrWidth-1:0] scaledIndex,
	input logic [aguPkg::boundWidth-1:0] bound,
	input aguPkg::aguCmd_t cmd,
	output logic outOfBounds
);

	logic checkEn;
	logic idxNeg;
	logic idxHigh;
	logic idxOver;
	logic roFault;

	assign checkEn = &bound[aguPkg::bndCheckHi:aguPkg::bndCheckLo];

	// negative indices have no lower window, always a fault
	assign idxNeg = scaledIndex[aguPkg::addrWidth-1];
	assign idxHigh = |scaledIndex[aguPkg::addrWidth-1:32];

	// compare in 16-byte units
	assign idxOver = scaledIndex[31:4] >= bound[aguPkg::bndLimitHi:aguPkg::bndLimitLo];

	// write to a read-only region
	assign roFault = bound[aguPkg::bndReadOnly] && (cmd == aguPkg::cmdStore);

	assign outOfBounds = checkEn && (idxNeg || idxHigh || idxOver || roFault ||
		bound[aguPkg::bndForceFault]);

endmodule

`default_nettype wire

/* hw/agu/addrGen.sv */
`timescale 1ns/1ps
`default_nettype none

module addrGen (
	input logic clock,
	input logic rstN,
	input logic opLoad,
	input logic [aguPkg::regWidth-1:0] base,
	input logic [aguPkg::regWidth-1:0] index,
	input logic [aguPkg::dispWidth-1:0] disp,
	input aguPkg::aguCmd_t cmd,
	input logic [aguPkg::ixtWidth-1:0] ixt,
	input logic wideAddr,
	output logic [aguPkg::addrWidth-1:0] genAddr,
	output logic [aguPkg::addrWidth-1:0] scaledIndex,
	output aguPkg::aguCmd_t cmdReg
);

	localparam int sw = aguPkg::sliceWidth;
	localparam int aw = aguPkg::addrWidth;

	logic [aw-1:0] baseReg;
	logic [31:0] indexReg;
	logic [aguPkg::dispWidth-1:0] dispReg;
	logic [aguPkg::ixtWidth-1:0] ixtReg;
	logic wideReg;

	logic extBit;
	logic [aw-1:0] extIndex;
	logic [aw-1:0] dispExt;
	logic [aw-1:0] csaSum;
	logic [aw-1:0] csaCarry;

	logic [sw:0] lowSum;
	logic [sw:0] midSum0;
	logic [sw:0] midSum1;
	logic [sw:0] midSel;
	logic [sw-1:0] highSum0;
	logic [sw-1:0] highSum1;
	logic [sw-1:0] highSlice;

	// operand payload, only the bits the adder needs
	always_ff @(posedge clock)
	begin
		if (opLoad)
		begin
			baseReg <= base[aw-1:0];
			indexReg <= index[31:0];
			dispReg <= disp;
			ixtReg <= ixt;
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			cmdReg <= aguPkg::cmdLea;
			wideReg <= 1'b0;
		end
		else if (opLoad)
		begin
			cmdReg <= cmd;
			wideReg <= wideAddr;
		end
	end

	// index extended from bit 31, then scaled by 1/2/4/8
	assign extBit = ixtReg[aguPkg::ixtZeroExt] ? 1'b0 : indexReg[31];
	assign extIndex = {{(aw - 32){extBit}}, indexReg};
	assign scaledIndex = extIndex << ixtReg[aguPkg::ixtScaleHi:aguPkg::ixtScaleLo];

	assign dispExt = ixtReg[aguPkg::ixtDispEn] ?
		{{(aw - aguPkg::dispWidth){dispReg[aguPkg::dispWidth-1]}}, dispReg} : '0;

	// 3:2 compress base, index and displacement first
	assign csaSum = baseReg ^ scaledIndex ^ dispExt;
	assign csaCarry = {((baseReg[aw-2:0] & scaledIndex[aw-2:0]) |
		(baseReg[aw-2:0] & dispExt[aw-2:0]) |
		(scaledIndex[aw-2:0] & dispExt[aw-2:0])), 1'b0};

	assign lowSum = {1'b0, csaSum[sw-1:0]} + {1'b0, csaCarry[sw-1:0]};

	// upper slices precomputed for both carry-in values
	assign midSum0 = {1'b0, csaSum[2*sw-1:sw]} + {1'b0, csaCarry[2*sw-1:sw]};
	assign midSum1 = {1'b0, csaSum[2*sw-1:sw]} + {1'b0, csaCarry[2*sw-1:sw]} + 1'b1;
	assign highSum0 = csaSum[3*sw-1:2*sw] + csaCarry[3*sw-1:2*sw];
	assign highSum1 = csaSum[3*sw-1:2*sw] + csaCarry[3*sw-1:2*sw] + 1'b1;

	assign midSel = lowSum[sw] ? midSum1 : midSum0;

	// top slice only in wide addressing mode
	assign highSlice = wideReg ? (midSel[sw] ? highSum1 : highSum0) : '0;

	assign genAddr = {highSlice, midSel[sw-1:0], lowSum[sw-1:0]};

endmodule

`default_nettype wire

/* common/aguPkg.sv */
`default_nettype none

package aguPkg;

	// datapath widths
	localparam int addrWidth = 48;
	localparam int regWidth = 64;
	localparam int dispWidth = 16;
	localparam int ixtWidth = 4;
	localparam int boundWidth = 34;

	// carry-select slice size of the address adder
	localparam int sliceWidth = 16;

	// memory micro-op command, value 3 is reserved and acts as lea
	typedef enum logic [1:0]
	{
		cmdLoad = 2'd0,
		cmdStore = 2'd1,
		cmdLea = 2'd2
	} aguCmd_t;

	// index-extension word
	localparam int ixtScaleLo = 0;
	localparam int ixtScaleHi = 1;
	// set for zero extension from bit 31
	localparam int ixtZeroExt = 2;
	localparam int ixtDispEn = 3;

	// bound descriptor, limit in 16-byte units
	localparam int bndLimitLo = 0;
	localparam int bndLimitHi = 27;
	localparam int bndReadOnly = 28;
	localparam int bndForceFault = 29;
	// both bits set to enable checking
	localparam int bndCheckLo = 32;
	localparam int bndCheckHi = 33;

endpackage

`default_nettype wire
